//--- src/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] instT;
    typedef logic [31:0] addrT;     // byte address
    typedef logic [31:0] immT;      // sign extended
    typedef logic [31:0] dataT;
    typedef logic [4:0]  regNameT;

    // NOP also stands for any illegal encoding
    typedef enum logic [5:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        NOP
    } opT;

endpackage

//--- src/instMem.sv
module instMem #(
    parameter int IMEM_WORDS = 64
) (
    input  logic         clk,
    input  logic         loadEn,
    input  cpuPkg::addrT loadAddr,
    input  cpuPkg::instT loadData,
    input  cpuPkg::addrT imemAddr,
    output cpuPkg::instT imemData
);

    localparam int AW = $clog2(IMEM_WORDS);

    cpuPkg::instT mem [IMEM_WORDS];

    logic [AW-1:0] loadIdx;
    logic [AW-1:0] readIdx;

    // byte addresses in, word index out
    assign loadIdx = loadAddr[AW+1:2];
    assign readIdx = imemAddr[AW+1:2];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end
        imemData <= mem[readIdx]; // one cycle read
    end

endmodule

//--- src/fetchCtrl.sv
module fetchCtrl (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic [31:0]  progLen,
    input  logic         rdy,
    output cpuPkg::addrT imemAddr,
    input  cpuPkg::instT imemData,
    output logic         instEn,
    output cpuPkg::instT inst,
    output cpuPkg::addrT pc,
    output logic         done
);

    typedef enum logic [1:0] {Idle, Fill, Run, Done} stateT;

    stateT       state;
    logic [31:0] count;  // instructions accepted so far
    logic        accept;

    assign instEn = (state == Run);
    assign accept = instEn && rdy;
    assign done   = (state == Done);

    // address the word that pc will hold next cycle, so the read lines up with pc
    assign imemAddr = accept ? pc + 32'd4 : pc;
    assign inst     = imemData; // stays put while stalled since the address does

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            pc    <= '0;
            count <= '0;
        end else begin
            case (state)
                Idle, Done: begin
                    if (start) begin
                        state <= Fill;
                        pc    <= '0;
                        count <= '0;
                    end
                end
                Fill: begin // word 0 is being read
                    state <= (progLen == 32'd0) ? Done : Run;
                end
                Run: begin
                    if (accept) begin
                        pc    <= pc + 32'd4;
                        count <= count + 32'd1;
                        if (count + 32'd1 == progLen) begin
                            state <= Done;
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

//--- src/decoder.sv
module decoder (
    input  logic            rdy,
    input  logic            instEn,
    input  cpuPkg::instT    inst,
    input  cpuPkg::addrT    pc,
    output logic            robEn,
    output cpuPkg::regNameT robRd,
    output logic            writesRd,
    output logic            rfEn,
    output cpuPkg::regNameT rs1,
    output cpuPkg::regNameT rs2,
    output cpuPkg::regNameT rd,
    output cpuPkg::opT      op,
    output cpuPkg::addrT    outPc,
    output cpuPkg::immT     imm
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [3:0] funct;  // bit 30 in front of funct3

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct  = {inst[30], inst[14:12]};

    assign robEn = rdy && instEn;
    assign rfEn  = rdy && instEn;
    assign rs1   = inst[19:15];
    assign rs2   = inst[24:20];
    assign rd    = inst[11:7];
    assign robRd = inst[11:7];
    assign outPc = pc;

    assign writesRd = (rd != 5'd0) && (op != cpuPkg::NOP)
                      && (opcode != OPC_BRANCH) && (opcode != OPC_STORE);

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = {inst[31:12], 12'b0};
            OPC_JAL:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OPC_BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_JALR, OPC_OPIMM, OPC_LOAD: imm = {{21{inst[31]}}, inst[30:20]};
            OPC_STORE:  imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:    imm = '0; // register-register ops carry none
        endcase
    end

    always_comb begin
        op = cpuPkg::NOP;
        case (opcode)
            OPC_LUI:   op = cpuPkg::LUI;
            OPC_AUIPC: op = cpuPkg::AUIPC;
            OPC_JAL:   op = cpuPkg::JAL;
            OPC_JALR:  op = cpuPkg::JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = cpuPkg::BEQ;
                    3'b001:  op = cpuPkg::BNE;
                    3'b100:  op = cpuPkg::BLT;
                    3'b101:  op = cpuPkg::BGE;
                    3'b110:  op = cpuPkg::BLTU;
                    3'b111:  op = cpuPkg::BGEU;
                    default: op = cpuPkg::NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = cpuPkg::LB;
                    3'b001:  op = cpuPkg::LH;
                    3'b010:  op = cpuPkg::LW;
                    3'b100:  op = cpuPkg::LBU;
                    3'b101:  op = cpuPkg::LHU;
                    default: op = cpuPkg::NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = cpuPkg::SB;
                    3'b001:  op = cpuPkg::SH;
                    3'b010:  op = cpuPkg::SW;
                    default: op = cpuPkg::NOP;
                endcase
            end
            OPC_OPIMM: begin
                case (funct3) // bit 30 only matters for the right shifts
                    3'b000:  op = cpuPkg::ADDI;
                    3'b010:  op = cpuPkg::SLTI;
                    3'b011:  op = cpuPkg::SLTIU;
                    3'b100:  op = cpuPkg::XORI;
                    3'b110:  op = cpuPkg::ORI;
                    3'b111:  op = cpuPkg::ANDI;
                    3'b001:  op = cpuPkg::SLLI;
                    default: op = inst[30] ? cpuPkg::SRAI : cpuPkg::SRLI;
                endcase
            end
            OPC_OP: begin
                case (funct)
                    4'b0000: op = cpuPkg::ADD;
                    4'b1000: op = cpuPkg::SUB;
                    4'b0001: op = cpuPkg::SLL;
                    4'b0010: op = cpuPkg::SLT;
                    4'b0011: op = cpuPkg::SLTU;
                    4'b0100: op = cpuPkg::XOR;
                    4'b0101: op = cpuPkg::SRL;
                    4'b1101: op = cpuPkg::SRA;
                    4'b0110: op = cpuPkg::OR;
                    4'b0111: op = cpuPkg::AND;
                    default: op = cpuPkg::NOP;
                endcase
            end
            default: op = cpuPkg::NOP;
        endcase
    end

endmodule

//--- src/robTagAlloc.sv
module robTagAlloc #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         robEn,
    input  cpuPkg::regNameT              robRd,
    input  logic                         writesRd,
    input  logic                         commitEn,
    output logic                         rdy,
    output logic [$clog2(ROB_DEPTH)-1:0] allocTag,
    output logic [$clog2(ROB_DEPTH)-1:0] headTag,
    output cpuPkg::regNameT              headRd,
    output logic                         headWrites
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W:0]  count; // entries in flight
    cpuPkg::regNameT rdRam [ROB_DEPTH];
    logic            wrRam [ROB_DEPTH];

    assign rdy        = (count != ROB_DEPTH);
    assign headRd     = rdRam[headTag];
    assign headWrites = wrRam[headTag];

    always_ff @(posedge clk) begin
        if (rst) begin
            allocTag <= '0;
            headTag  <= '0;
            count    <= '0;
        end else begin
            if (robEn) begin
                allocTag <= allocTag + 1'b1; // wraps at ROB_DEPTH
            end
            if (commitEn) begin
                headTag <= headTag + 1'b1;
            end
            case ({robEn, commitEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // commit needs to know which register the head entry targets
    always_ff @(posedge clk) begin
        if (robEn) begin
            rdRam[allocTag] <= robRd;
            wrRam[allocTag] <= writesRd;
        end
    end

endmodule

//--- src/renameRegFile.sv
module renameRegFile #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rfEn,
    input  cpuPkg::regNameT              rs1,
    input  cpuPkg::regNameT              rs2,
    input  cpuPkg::regNameT              rd,
    input  logic                         writesRd,
    input  cpuPkg::opT                   op,
    input  cpuPkg::addrT                 pc,
    input  cpuPkg::immT                  imm,
    input  logic [$clog2(ROB_DEPTH)-1:0] allocTag,
    input  logic                         commitEn,
    input  cpuPkg::dataT                 commitData,
    input  logic [$clog2(ROB_DEPTH)-1:0] headTag,
    input  cpuPkg::regNameT              headRd,
    input  logic                         headWrites,
    output logic                         dispEn,
    output cpuPkg::opT                   dispOp,
    output cpuPkg::addrT                 dispPc,
    output cpuPkg::immT                  dispImm,
    output cpuPkg::regNameT              dispRd,
    output logic [$clog2(ROB_DEPTH)-1:0] dispTag,
    output logic                         dispRs1Busy,
    output logic [$clog2(ROB_DEPTH)-1:0] dispRs1Tag,
    output cpuPkg::dataT                 dispRs1Val,
    output logic                         dispRs2Busy,
    output logic [$clog2(ROB_DEPTH)-1:0] dispRs2Tag,
    output cpuPkg::dataT                 dispRs2Val
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    cpuPkg::dataT     regVal [32];
    logic [TAG_W-1:0] regTag [32];
    logic [31:0]      busy;     // x0 is never marked since writesRd excludes it
    logic             commitWr; // head is still the newest writer of headRd
    logic             rs1Fwd;
    logic             rs2Fwd;

    assign commitWr = commitEn && headWrites && busy[headRd] && (regTag[headRd] == headTag);
    assign rs1Fwd   = commitWr && (rs1 == headRd);
    assign rs2Fwd   = commitWr && (rs2 == headRd);

    always_ff @(posedge clk) begin
        if (rst) begin
            dispEn <= 1'b0;
            busy   <= '0;
            regVal <= '{default: '0};
            regTag <= '{default: '0};
        end else begin
            dispEn <= rfEn;
            if (commitWr) begin
                regVal[headRd] <= commitData;
                busy[headRd]   <= 1'b0;
            end
            if (rfEn && writesRd) begin // newer writer wins over a same-cycle commit
                busy[rd]   <= 1'b1;
                regTag[rd] <= allocTag;
            end
        end
    end

    // a commit in the same cycle is seen by the lookup
    always_ff @(posedge clk) begin
        if (rfEn) begin
            dispOp      <= op;
            dispPc      <= pc;
            dispImm     <= imm;
            dispRd      <= rd;
            dispTag     <= allocTag;
            dispRs1Busy <= busy[rs1] && !rs1Fwd;
            dispRs1Tag  <= regTag[rs1];
            dispRs1Val  <= rs1Fwd ? commitData : regVal[rs1];
            dispRs2Busy <= busy[rs2] && !rs2Fwd;
            dispRs2Tag  <= regTag[rs2];
            dispRs2Val  <= rs2Fwd ? commitData : regVal[rs2];
        end
    end

endmodule

//--- src/frontEnd.sv
module frontEnd #(
    parameter int ROB_DEPTH  = 8,
    parameter int IMEM_WORDS = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         loadEn,
    input  cpuPkg::addrT                 loadAddr,
    input  cpuPkg::instT                 loadData,
    input  logic                         start,
    input  logic [31:0]                  progLen,
    output logic                         done,
    input  logic                         commitEn,
    input  cpuPkg::dataT                 commitData,
    output logic                         dispEn,
    output cpuPkg::opT                   dispOp,
    output cpuPkg::addrT                 dispPc,
    output cpuPkg::immT                  dispImm,
    output cpuPkg::regNameT              dispRd,
    output logic [$clog2(ROB_DEPTH)-1:0] dispTag,
    output logic                         dispRs1Busy,
    output logic [$clog2(ROB_DEPTH)-1:0] dispRs1Tag,
    output cpuPkg::dataT                 dispRs1Val,
    output logic                         dispRs2Busy,
    output logic [$clog2(ROB_DEPTH)-1:0] dispRs2Tag,
    output cpuPkg::dataT                 dispRs2Val
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    cpuPkg::addrT     imemAddr;
    cpuPkg::instT     imemData;
    logic             instEn;
    cpuPkg::instT     inst;
    cpuPkg::addrT     pc;
    logic             rdy;
    logic             robEn;
    cpuPkg::regNameT  robRd;
    logic             writesRd;
    logic             rfEn;
    cpuPkg::regNameT  rs1;
    cpuPkg::regNameT  rs2;
    cpuPkg::regNameT  rd;
    cpuPkg::opT       op;
    cpuPkg::addrT     decPc;
    cpuPkg::immT      imm;
    logic [TAG_W-1:0] allocTag;
    logic [TAG_W-1:0] headTag;
    cpuPkg::regNameT  headRd;
    logic             headWrites;

    instMem #(.IMEM_WORDS(IMEM_WORDS)) i_instMem (
        .clk      (clk),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .imemAddr (imemAddr),
        .imemData (imemData)
    );

    fetchCtrl i_fetchCtrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .progLen  (progLen),
        .rdy      (rdy),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .instEn   (instEn),
        .inst     (inst),
        .pc       (pc),
        .done     (done)
    );

    decoder i_decoder (
        .rdy      (rdy),
        .instEn   (instEn),
        .inst     (inst),
        .pc       (pc),
        .robEn    (robEn),
        .robRd    (robRd),
        .writesRd (writesRd),
        .rfEn     (rfEn),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .op       (op),
        .outPc    (decPc),
        .imm      (imm)
    );

    robTagAlloc #(.ROB_DEPTH(ROB_DEPTH)) i_robTagAlloc (
        .clk        (clk),
        .rst        (rst),
        .robEn      (robEn),
        .robRd      (robRd),
        .writesRd   (writesRd),
        .commitEn   (commitEn),
        .rdy        (rdy),
        .allocTag   (allocTag),
        .headTag    (headTag),
        .headRd     (headRd),
        .headWrites (headWrites)
    );

    renameRegFile #(.ROB_DEPTH(ROB_DEPTH)) i_renameRegFile (
        .clk         (clk),
        .rst         (rst),
        .rfEn        (rfEn),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .writesRd    (writesRd),
        .op          (op),
        .pc          (decPc),
        .imm         (imm),
        .allocTag    (allocTag),
        .commitEn    (commitEn),
        .commitData  (commitData),
        .headTag     (headTag),
        .headRd      (headRd),
        .headWrites  (headWrites),
        .dispEn      (dispEn),
        .dispOp      (dispOp),
        .dispPc      (dispPc),
        .dispImm     (dispImm),
        .dispRd      (dispRd),
        .dispTag     (dispTag),
        .dispRs1Busy (dispRs1Busy),
        .dispRs1Tag  (dispRs1Tag),
        .dispRs1Val  (dispRs1Val),
        .dispRs2Busy (dispRs2Busy),
        .dispRs2Tag  (dispRs2Tag),
        .dispRs2Val  (dispRs2Val)
    );

endmodule

//--- test/frontEndModel.svh
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

// op tables from the RV32I encoding, indexed by funct3 or by {bit 30, funct3}
cpuPkg::opT branchOps [8] = '{cpuPkg::BEQ, cpuPkg::BNE, cpuPkg::NOP, cpuPkg::NOP,
                              cpuPkg::BLT, cpuPkg::BGE, cpuPkg::BLTU, cpuPkg::BGEU};
cpuPkg::opT loadOps [8]   = '{cpuPkg::LB, cpuPkg::LH, cpuPkg::LW, cpuPkg::NOP,
                              cpuPkg::LBU, cpuPkg::LHU, cpuPkg::NOP, cpuPkg::NOP};
cpuPkg::opT storeOps [8]  = '{cpuPkg::SB, cpuPkg::SH, cpuPkg::SW, cpuPkg::NOP,
                              cpuPkg::NOP, cpuPkg::NOP, cpuPkg::NOP, cpuPkg::NOP};
cpuPkg::opT immOps [8]    = '{cpuPkg::ADDI, cpuPkg::SLLI, cpuPkg::SLTI, cpuPkg::SLTIU,
                              cpuPkg::XORI, cpuPkg::SRLI, cpuPkg::ORI, cpuPkg::ANDI};
cpuPkg::opT regOps [16]   = '{cpuPkg::ADD, cpuPkg::SLL, cpuPkg::SLT, cpuPkg::SLTU,
                              cpuPkg::XOR, cpuPkg::SRL, cpuPkg::OR, cpuPkg::AND,
                              cpuPkg::SUB, cpuPkg::NOP, cpuPkg::NOP, cpuPkg::NOP,
                              cpuPkg::NOP, cpuPkg::SRA, cpuPkg::NOP, cpuPkg::NOP};

// architectural state as the rename stage should present it
cpuPkg::dataT modelVal [32]  = '{default: '0};
logic         modelBusy [32] = '{default: 1'b0};
int           modelTag [32]  = '{default: 0};
int           robRdQ [$];    // entries in flight, oldest first
int           robTagQ [$];
logic         robWrQ [$];

function automatic cpuPkg::opT opOf(input cpuPkg::instT word);
    cpuPkg::opT op;
    logic [2:0] f3;
    f3 = word[14:12];
    case (word[6:0])
        7'h37:   op = cpuPkg::LUI;
        7'h17:   op = cpuPkg::AUIPC;
        7'h6f:   op = cpuPkg::JAL;
        7'h67:   op = cpuPkg::JALR;
        7'h63:   op = branchOps[f3];
        7'h03:   op = loadOps[f3];
        7'h23:   op = storeOps[f3];
        7'h13:   op = (f3 == 3'd5 && word[30]) ? cpuPkg::SRAI : immOps[f3];
        7'h33:   op = regOps[{word[30], f3}];
        default: op = cpuPkg::NOP;
    endcase
    return op;
endfunction

function automatic cpuPkg::immT immOf(input cpuPkg::instT word);
    logic signed [31:0] v;
    case (word[6:0])
        7'h37, 7'h17:        v = {word[31:12], 12'h000};
        7'h6f:               v = 32'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
        7'h63:               v = 32'($signed({word[31], word[7], word[30:25], word[11:8], 1'b0}));
        7'h67, 7'h03, 7'h13: v = 32'($signed(word[31:20]));
        7'h23:               v = 32'($signed({word[31:25], word[11:7]}));
        default:             v = '0;
    endcase
    return v;
endfunction

function automatic logic hasDest(input cpuPkg::instT word);
    cpuPkg::opT op;
    op = opOf(word);
    return (word[11:7] != 5'd0) && !(op inside {cpuPkg::NOP, cpuPkg::BEQ, cpuPkg::BNE,
        cpuPkg::BLT, cpuPkg::BGE, cpuPkg::BLTU, cpuPkg::BGEU, cpuPkg::SB, cpuPkg::SH,
        cpuPkg::SW});
endfunction

// head retires, register updated only if the head is still its newest writer
task automatic retireHead(input cpuPkg::dataT data);
    int   rd;
    int   tag;
    logic wr;
    if (robTagQ.size() > 0) begin
        rd  = robRdQ.pop_front();
        tag = robTagQ.pop_front();
        wr  = robWrQ.pop_front();
        if (wr && modelBusy[rd] && modelTag[rd] == tag) begin
            modelVal[rd]  = data;
            modelBusy[rd] = 1'b0;
        end
    end
endtask

task automatic allocateEntry(input int rd, input logic wr, input int tag);
    robRdQ.push_back(rd);
    robTagQ.push_back(tag);
    robWrQ.push_back(wr);
    if (wr) begin
        modelBusy[rd] = 1'b1;
        modelTag[rd]  = tag;
    end
endtask

`endif

//--- test/tbFrontEnd.sv
module tbFrontEnd;

    localparam int ROB_DEPTH  = 8;
    localparam int IMEM_WORDS = 64;
    localparam int TAG_W      = $clog2(ROB_DEPTH);
    localparam int FIXED_LEN  = 19;
    localparam int PROG_LEN   = 40;

    logic             clk;
    logic             rst;
    logic             loadEn;
    cpuPkg::addrT     loadAddr;
    cpuPkg::instT     loadData;
    logic             start;
    logic [31:0]      progLen;
    logic             done;
    logic             commitEn;
    cpuPkg::dataT     commitData;
    logic             dispEn;
    cpuPkg::opT       dispOp;
    cpuPkg::addrT     dispPc;
    cpuPkg::immT      dispImm;
    cpuPkg::regNameT  dispRd;
    logic [TAG_W-1:0] dispTag;
    logic             dispRs1Busy;
    logic [TAG_W-1:0] dispRs1Tag;
    cpuPkg::dataT     dispRs1Val;
    logic             dispRs2Busy;
    logic [TAG_W-1:0] dispRs2Tag;
    cpuPkg::dataT     dispRs2Val;

    cpuPkg::instT prog [PROG_LEN];
    integer       seed;
    int           errors      = 0;
    int           errBase     = 0;
    int           testsRun    = 0;
    int           testsFailed = 0;
    int           dispCount   = 0; // compare side
    int           allocCount  = 0;
    logic         doneSeen    = 1'b0;
    int           seenDisp    = 0; // stimulus side
    int           inFlight    = 0;
    logic         timedOut    = 1'b0;
    logic         sawCommit;
    cpuPkg::dataT sawData;

    `include "frontEndModel.svh"

    frontEnd #(.ROB_DEPTH(ROB_DEPTH), .IMEM_WORDS(IMEM_WORDS)) i_frontEnd (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic cpuPkg::instT immInst(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpuPkg::instT regRegInst(input logic b30, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, 7'h33};
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        prog[0]  = {20'h80001, 5'd1, 7'h37};                           // lui
        prog[1]  = {20'hfffff, 5'd2, 7'h17};                           // auipc
        prog[2]  = {1'b1, 10'h3fe, 1'b1, 8'hff, 5'd3, 7'h6f};          // negative jal
        prog[3]  = immInst(12'hff8, 5'd1, 3'd0, 5'd4, 7'h67);          // jalr
        prog[4]  = {7'h40, 5'd2, 5'd1, 3'd0, 5'h01, 7'h63};            // negative beq
        prog[5]  = {7'h3f, 5'd3, 5'd4, 3'd7, 5'h1e, 7'h63};            // bgeu
        prog[6]  = {7'h00, 5'd1, 5'd1, 3'd2, 5'h04, 7'h63};            // bad branch funct3
        prog[7]  = immInst(12'hfff, 5'd2, 3'd2, 5'd5, 7'h03);          // lw
        prog[8]  = immInst(12'h7ff, 5'd1, 3'd4, 5'd6, 7'h03);          // lbu
        prog[9]  = immInst(12'h010, 5'd1, 3'd3, 5'd7, 7'h03);          // bad load funct3
        prog[10] = {7'h7f, 5'd5, 5'd1, 3'd2, 5'h10, 7'h23};            // negative sw
        prog[11] = {7'h01, 5'd6, 5'd2, 3'd4, 5'h02, 7'h23};            // bad store funct3
        prog[12] = immInst(12'h403, 5'd1, 3'd5, 5'd6, 7'h13);          // srai
        prog[13] = immInst(12'hffe, 5'd5, 3'd3, 5'd7, 7'h13);          // sltiu
        prog[14] = regRegInst(1'b1, 5'd6, 5'd5, 3'd0, 5'd7);           // sub
        prog[15] = regRegInst(1'b1, 5'd2, 5'd3, 3'd1, 5'd1);           // bad op encoding
        prog[16] = immInst(12'h005, 5'd1, 3'd0, 5'd0, 7'h13);          // addi to x0
        prog[17] = 32'hffff_ffff;                                      // unknown opcode
        prog[18] = regRegInst(1'b1, 5'd0, 5'd7, 3'd5, 5'd3);           // sra
        // only x0..x7 so sources often hit an in-flight writer
        for (int i = FIXED_LEN; i < PROG_LEN; i++) begin
            r = $random(seed);
            if (r[0]) begin
                prog[i] = regRegInst(r[1], {2'b00, r[4:2]}, {2'b00, r[7:5]}, r[10:8],
                                     {2'b00, r[13:11]});
            end else begin
                prog[i] = immInst(r[27:16], {2'b00, r[7:5]}, r[10:8], {2'b00, r[13:11]},
                                  7'h13);
            end
        end
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic flagTimeout(input string what);
        timedOut = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic checkSource(input string name, input cpuPkg::regNameT r, input logic busyBit,
                               input logic [TAG_W-1:0] tag, input cpuPkg::dataT val);
        if (busyBit != modelBusy[r]) begin
            reportError($sformatf("%s x%0d busy %b, expected %b", name, r, busyBit,
                                  modelBusy[r]));
        end else if (busyBit && int'(tag) != modelTag[r]) begin
            reportError($sformatf("%s x%0d tag %0d, expected %0d", name, r, tag, modelTag[r]));
        end else if (!busyBit && val != modelVal[r]) begin
            reportError($sformatf("%s x%0d value %h, expected %h", name, r, val, modelVal[r]));
        end
    endtask

    task automatic checkDispatch();
        cpuPkg::instT word;
        int           idx;
        idx = dispCount;
        dispCount++;
        if (idx >= PROG_LEN) begin
            reportError($sformatf("extra dispatch at pc %h", dispPc));
        end else begin
            word = prog[idx];
            if (dispPc != 32'(idx * 4)) begin
                reportError($sformatf("pc %h, expected %h", dispPc, 32'(idx * 4)));
            end
            if (dispOp != opOf(word)) begin
                reportError($sformatf("pc %h op %0d, expected %0d", dispPc, dispOp, opOf(word)));
            end
            if (dispImm != immOf(word)) begin
                reportError($sformatf("pc %h imm %h, expected %h", dispPc, dispImm, immOf(word)));
            end
            if (dispRd != word[11:7]) begin
                reportError($sformatf("pc %h rd %0d, expected %0d", dispPc, dispRd, word[11:7]));
            end
            if (int'(dispTag) != allocCount % ROB_DEPTH) begin
                reportError($sformatf("pc %h tag %0d, expected %0d", dispPc, dispTag,
                                      allocCount % ROB_DEPTH));
            end
            checkSource("rs1", word[19:15], dispRs1Busy, dispRs1Tag, dispRs1Val);
            checkSource("rs2", word[24:20], dispRs2Busy, dispRs2Tag, dispRs2Val);
            allocateEntry(int'(word[11:7]), hasDest(word), allocCount % ROB_DEPTH);
            allocCount++;
        end
    endtask

    // compare process runs once per cycle
    always begin
        @(posedge clk);
        sawCommit = commitEn; // stable since the falling edge
        sawData   = commitData;
        @(negedge clk);
        if (sawCommit) begin
            retireHead(sawData); // a same-edge commit is visible to the lookup
        end
        if (dispEn) begin
            checkDispatch();
        end
        if (done && !doneSeen) begin
            doneSeen = 1'b1;
            if (dispCount != PROG_LEN) begin
                reportError($sformatf("done after %0d dispatches, expected %0d", dispCount,
                                      PROG_LEN));
            end
        end
    end

    // counts the last rising edge and drives the next commit on a falling edge
    task automatic step(input logic wantCommit);
        @(negedge clk);
        if (dispEn) begin
            seenDisp++;
            inFlight++;
        end
        if (commitEn) begin
            inFlight--;
        end
        commitEn   = wantCommit && (inFlight > 0);
        commitData = $random(seed);
    endtask

    task automatic finishTest(input string name);
        @(posedge clk);
        testsRun++;
        if (errors != errBase || timedOut) begin
            testsFailed++;
            $display("test %s: fail, %0d errors", name, errors - errBase);
        end else begin
            $display("test %s: pass", name);
        end
        errBase = errors;
    endtask

    initial begin
        int waitCycles;
        seed       = 32'h998ee756;
        rst        = 1'b1;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        start      = 1'b0;
        progLen    = '0;
        commitEn   = 1'b0;
        commitData = '0;
        buildProgram();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (dispEn !== 1'b0 || done !== 1'b0) begin
            reportError($sformatf("after reset dispEn %b done %b, expected 0 0", dispEn, done));
        end
        finishTest("reset");

        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = 32'(i * 4);
            loadData = prog[i];
        end
        @(negedge clk);
        loadEn  = 1'b0;
        progLen = PROG_LEN;
        start   = 1'b1;
        step(1'b0);
        start   = 1'b0;

        // no commits, so the ROB fills and fetch has to stall
        waitCycles = 0;
        while (seenDisp < ROB_DEPTH && waitCycles < 50) begin
            step(1'b0);
            waitCycles++;
        end
        if (seenDisp < ROB_DEPTH) begin
            flagTimeout($sformatf("only %0d dispatches while the ROB was filling", seenDisp));
        end
        repeat (10) step(1'b0);
        if (seenDisp != ROB_DEPTH || done) begin
            reportError($sformatf("%0d dispatches with no commits, expected %0d", seenDisp,
                                  ROB_DEPTH));
        end
        finishTest("back-pressure");

        if (!timedOut) begin
            waitCycles = 0;
            while ((seenDisp < PROG_LEN || !done) && waitCycles < 2000) begin
                step(($random(seed) & 3) != 0);
                waitCycles++;
            end
            if (seenDisp < PROG_LEN || !done) begin
                flagTimeout("the front end stopped dispatching or never raised done");
            end
            finishTest("dispatch with commits");
        end

        if (!timedOut) begin
            waitCycles = 0;
            while (inFlight > 0 && waitCycles < 100) begin
                step(1'b1);
                waitCycles++;
            end
            if (inFlight > 0) begin
                flagTimeout($sformatf("%0d entries still in flight after draining", inFlight));
            end
            step(1'b0);
            if (!done || seenDisp != PROG_LEN) begin
                reportError($sformatf("after drain done %b with %0d dispatches", done, seenDisp));
            end
            finishTest("retire");
        end

        $display("%0d tests, %0d failed, %0d dispatches checked, %0d errors", testsRun,
                 testsFailed, dispCount, errors);
        if (errors == 0 && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+test
src/cpuPkg.sv
src/instMem.sv
src/fetchCtrl.sv
src/decoder.sv
src/robTagAlloc.sv
src/renameRegFile.sv
src/frontEnd.sv
test/tbFrontEnd.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbFrontEnd
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= sim passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard test/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
